// File: flist.f
+incdir+include
logic/core_pkg.sv
logic/ifu_stage.sv
logic/credit_fifo.sv
logic/exu_stage.sv
logic/regfile.sv
logic/cpu_core.sv
tb/tb_cpu_core.sv

// File: run.sh
#!/bin/sh
# build and run the cpu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_cpu_core \
	-o sim_tb_cpu_core > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/sim_tb_cpu_core > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "TEST PASS" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// File: tb/tb_cpu_core.sv
`include "core_config.svh"

module tb_cpu_core
	import core_pkg::*;
;

	logic        clock;
	logic        rst_n_i;
	logic        inst_req_o;
	logic [31:0] inst_addr_o;
	logic        inst_gnt_i;
	logic        inst_rvalid_i;
	logic [31:0] inst_data_i;
	logic        retire_valid_o;
	logic        retire_ready_i;
	retire_t     retire_o;

	logic [31:0] imem [256];
	logic [31:0] ref_regs [32];
	integer      seed = 32'hb0ed;
	int          prog_len = 0;
	int          retired = 0;
	int          grants = 0;
	int          checks = 0;
	int          errors = 0;
	int          tests = 0;
	int          ready_mode = 0;
	logic [31:0] exp_pc = `CORE_RESET_PC;
	retire_t     expected;

	cpu_core dut (
		.clock          (clock),
		.rst_n_i        (rst_n_i),
		.inst_req_o     (inst_req_o),
		.inst_addr_o    (inst_addr_o),
		.inst_gnt_i     (inst_gnt_i),
		.inst_rvalid_i  (inst_rvalid_i),
		.inst_data_i    (inst_data_i),
		.retire_valid_o (retire_valid_o),
		.retire_ready_i (retire_ready_i),
		.retire_o       (retire_o)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timeout: %s did not happen in time", what);
		$display("TEST FAIL");
		$finish;
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		$display("test %0d %s finished with %0d errors", tests, name, errors - err_before);
	endtask

	// encoders for the three instruction formats
	function automatic logic [31:0] itype_inst(input logic [2:0] f3, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, OP_IMM};
	endfunction

	function automatic logic [31:0] rtype_inst(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, OP_REG};
	endfunction

	function automatic logic [31:0] utype_inst(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, OP_LUI};
	endfunction

	task automatic append_inst(input logic [31:0] inst);
		imem[prog_len] = inst;
		prog_len++;
	endtask

	// software model of one instruction that steps ref_regs
	function automatic retire_t ref_retire(input logic [31:0] pc, input logic [31:0] inst);
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] res;
		logic        ok;
		retire_t     r;
		rd  = inst[11:7];
		f3  = inst[14:12];
		f7  = inst[31:25];
		a   = ref_regs[inst[19:15]];
		b   = ref_regs[inst[24:20]];
		imm = {{20{inst[31]}}, inst[31:20]};
		ok  = 1'b1;
		res = 32'd0;
		case (inst[6:0])
			OP_IMM: begin
				case (f3)
					3'b000:  res = a + imm;
					3'b100:  res = a ^ imm;
					3'b110:  res = a | imm;
					3'b111:  res = a & imm;
					default: ok = 1'b0;
				endcase
			end
			OP_REG: begin
				if (f7 == 7'b0000000) begin
					case (f3)
						3'b000:  res = a + b;
						3'b100:  res = a ^ b;
						3'b110:  res = a | b;
						3'b111:  res = a & b;
						default: ok = 1'b0;
					endcase
				end else if (f7 == 7'b0100000 && f3 == 3'b000) begin
					res = a - b;
				end else begin
					ok = 1'b0;
				end
			end
			OP_LUI:  res = {inst[31:12], 12'h000};
			default: ok = 1'b0;
		endcase
		if (ok && rd != 5'd0) begin
			ref_regs[rd] = res;
		end
		r.pc      = pc;
		r.rd      = rd;
		r.wdata   = ok ? res : 32'd0;
		r.wen     = ok && (rd != 5'd0);
		r.illegal = !ok;
		return r;
	endfunction

	// instruction memory with random grant and data delays
	initial begin
		logic [31:0] addr;
		int          d;
		inst_gnt_i    = 1'b0;
		inst_rvalid_i = 1'b0;
		inst_data_i   = 32'd0;
		forever begin
			@(negedge clock);
			if (rst_n_i && inst_req_o) begin
				d = {$random(seed)} % 4;
				repeat (d) @(negedge clock);
				inst_gnt_i = 1'b1;
				addr = inst_addr_o;
				grants++;
				@(negedge clock);
				inst_gnt_i = 1'b0;
				d = {$random(seed)} % 4;
				repeat (d) @(negedge clock);
				inst_rvalid_i = 1'b1;
				inst_data_i   = imem[addr[9:2]];
				@(negedge clock);
				inst_rvalid_i = 1'b0;
			end
		end
	end

	// retire sink mode 0 is always ready, 1 stalled and 2 random
	always @(negedge clock) begin
		case (ready_mode)
			0:       retire_ready_i <= 1'b1;
			1:       retire_ready_i <= 1'b0;
			default: retire_ready_i <= 1'($random(seed));
		endcase
	end

	// compare each accepted record against the model
	always @(posedge clock) begin
		if (rst_n_i && retire_valid_o && retire_ready_i) begin
			expected = ref_retire(exp_pc, imem[exp_pc[9:2]]);
			check_value("retire_o.pc", retire_o.pc, expected.pc);
			check_value("retire_o.rd", {27'd0, retire_o.rd}, {27'd0, expected.rd});
			check_value("retire_o.wdata", retire_o.wdata, expected.wdata);
			check_value("retire_o.wen", {31'd0, retire_o.wen}, {31'd0, expected.wen});
			check_value("retire_o.illegal", {31'd0, retire_o.illegal},
				{31'd0, expected.illegal});
			exp_pc  = exp_pc + 32'd4;
			retired = retired + 1;
		end
	end

	task automatic wait_retired(input int target, input int limit);
		int n;
		n = 0;
		while (retired < target) begin
			@(negedge clock);
			n++;
			if (n > limit) begin
				abort_on_timeout("retire of the expected records");
			end
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [4:0]  rd;
		int          err_before;
		int          held;
		rst_n_i        = 1'b0;
		retire_ready_i = 1'b1;
		for (int i = 0; i < 32; i++) begin
			ref_regs[i] = 32'd0;
		end
		// ADDI x0,x0,0 everywhere past the program
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'h0000_0013;
		end
		append_inst(itype_inst(3'b000, 5'd1, 5'd0, -12'sd5));
		append_inst(itype_inst(3'b000, 5'd2, 5'd1, -12'sd100));
		append_inst(itype_inst(3'b111, 5'd3, 5'd2, -12'sd16));
		append_inst(itype_inst(3'b110, 5'd4, 5'd1, -12'sd256));
		append_inst(itype_inst(3'b100, 5'd5, 5'd4, -12'sd1));
		append_inst(itype_inst(3'b000, 5'd6, 5'd5, 12'h800));
		append_inst(rtype_inst(7'h00, 3'b000, 5'd7, 5'd1, 5'd2));
		append_inst(rtype_inst(7'h20, 3'b000, 5'd8, 5'd2, 5'd1));
		append_inst(rtype_inst(7'h00, 3'b111, 5'd9, 5'd3, 5'd4));
		append_inst(rtype_inst(7'h00, 3'b110, 5'd10, 5'd5, 5'd6));
		append_inst(rtype_inst(7'h00, 3'b100, 5'd11, 5'd7, 5'd8));
		append_inst(rtype_inst(7'h00, 3'b000, 5'd0, 5'd1, 5'd2));
		append_inst(rtype_inst(7'h20, 3'b000, 5'd12, 5'd0, 5'd1));
		append_inst(itype_inst(3'b000, 5'd13, 5'd0, 12'd7));
		append_inst(utype_inst(5'd14, 20'habcde));
		append_inst(utype_inst(5'd15, 20'hfffff));
		append_inst(rtype_inst(7'h00, 3'b000, 5'd16, 5'd14, 5'd15));
		append_inst(32'hffff_ffff);
		append_inst(32'h0000_0f8f);
		append_inst(rtype_inst(7'h01, 3'b000, 5'd18, 5'd1, 5'd2));
		append_inst(rtype_inst(7'h00, 3'b100, 5'd19, 5'd14, 5'd3));
		for (int i = 0; i < 24; i++) begin
			r  = $random(seed);
			rd = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
			case (r[6:5])
				2'd0:    append_inst(itype_inst(3'b000, rd, r[11:7], r[23:12]));
				2'd1:    append_inst(itype_inst(3'b100, rd, r[11:7], r[23:12]));
				2'd2:    append_inst(rtype_inst(7'h00, 3'b000, rd, r[11:7], r[16:12]));
				default: append_inst(rtype_inst(7'h20, 3'b000, rd, r[11:7], r[16:12]));
			endcase
		end

		err_before = errors;
		repeat (5) @(negedge clock);
		check_value("inst_req_o", {31'd0, inst_req_o}, 32'd0);
		check_value("retire_valid_o", {31'd0, retire_valid_o}, 32'd0);
		rst_n_i = 1'b1;
		@(negedge clock);
		check_value("inst_req_o", {31'd0, inst_req_o}, 32'd1);
		check_value("inst_addr_o", inst_addr_o, `CORE_RESET_PC);
		report_test("reset and first fetch", err_before);

		err_before = errors;
		wait_retired(6, 200);
		report_test("immediate ops", err_before);
		err_before = errors;
		wait_retired(14, 200);
		report_test("register ops and x0", err_before);
		err_before = errors;
		wait_retired(17, 200);
		report_test("lui", err_before);
		err_before = errors;
		wait_retired(21, 200);
		report_test("illegal encodings", err_before);

		// with the sink stalled the pipeline holds only what fits in the queues
		err_before = errors;
		ready_mode = 1;
		@(negedge clock);
		held = retired;
		repeat (40) @(negedge clock);
		check_value("retired during stall", retired, held);
		check_value("fetches beyond queue space",
			((grants - retired) <= `CORE_FQ_DEPTH + `CORE_RQ_DEPTH) ? 32'd1 : 32'd0, 32'd1);
		ready_mode = 2;
		wait_retired(prog_len, 1000);
		report_test("back-pressure", err_before);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: logic/cpu_core.sv
`include "core_config.svh"

module cpu_core
	import core_pkg::*;
(
	input  logic        clock,
	input  logic        rst_n_i,

	// instruction port
	output logic        inst_req_o,
	output logic [31:0] inst_addr_o,
	input  logic        inst_gnt_i,
	input  logic        inst_rvalid_i,
	input  logic [31:0] inst_data_i,

	// retire port, plain valid/ready
	output logic        retire_valid_o,
	input  logic        retire_ready_i,
	output retire_t     retire_o
);

	// fetch bus
	logic        fq_push;
	fs_to_ds_t   fq_push_data;
	logic        fq_valid;
	fs_to_ds_t   fq_data;
	logic        fq_pop;
	logic        fq_credit;

	// retire bus
	logic        rq_push;
	retire_t     rq_push_data;
	logic        rq_credit;

	// register file ports
	logic [4:0]  rs1_addr;
	logic [4:0]  rs2_addr;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	logic        rd_wen;
	logic [4:0]  rd_addr;
	logic [31:0] rd_wdata;

	ifu_stage u_ifu_stage (
		.clock         (clock),
		.rst_n_i       (rst_n_i),
		.inst_req_o    (inst_req_o),
		.inst_addr_o   (inst_addr_o),
		.inst_gnt_i    (inst_gnt_i),
		.inst_rvalid_i (inst_rvalid_i),
		.inst_data_i   (inst_data_i),
		.credit_i      (fq_credit),
		.push_o        (fq_push),
		.push_data_o   (fq_push_data)
	);

	credit_fifo #(
		.payload_t (fs_to_ds_t),
		.DEPTH     (`CORE_FQ_DEPTH)
	) fetch_queue (
		.clock       (clock),
		.rst_n_i     (rst_n_i),
		.push_i      (fq_push),
		.push_data_i (fq_push_data),
		.pop_i       (fq_pop),
		.valid_o     (fq_valid),
		.data_o      (fq_data),
		.credit_o    (fq_credit)
	);

	exu_stage u_exu_stage (
		.clock       (clock),
		.rst_n_i     (rst_n_i),
		.fq_valid_i  (fq_valid),
		.fq_data_i   (fq_data),
		.fq_pop_o    (fq_pop),
		.rq_credit_i (rq_credit),
		.rq_push_o   (rq_push),
		.rq_data_o   (rq_push_data),
		.rs1_addr_o  (rs1_addr),
		.rs2_addr_o  (rs2_addr),
		.rs1_data_i  (rs1_data),
		.rs2_data_i  (rs2_data),
		.rd_wen_o    (rd_wen),
		.rd_addr_o   (rd_addr),
		.rd_wdata_o  (rd_wdata)
	);

	// the outside pops by accepting a record
	credit_fifo #(
		.payload_t (retire_t),
		.DEPTH     (`CORE_RQ_DEPTH)
	) retire_queue (
		.clock       (clock),
		.rst_n_i     (rst_n_i),
		.push_i      (rq_push),
		.push_data_i (rq_push_data),
		.pop_i       (retire_valid_o & retire_ready_i),
		.valid_o     (retire_valid_o),
		.data_o      (retire_o),
		.credit_o    (rq_credit)
	);

	regfile u_regfile (
		.clock    (clock),
		.rst_n_i  (rst_n_i),
		.raddr1_i (rs1_addr),
		.raddr2_i (rs2_addr),
		.rdata1_o (rs1_data),
		.rdata2_o (rs2_data),
		.wen_i    (rd_wen),
		.waddr_i  (rd_addr),
		.wdata_i  (rd_wdata)
	);

endmodule

// File: logic/regfile.sv
`include "core_config.svh"

module regfile (
	input  logic        clock,
	input  logic        rst_n_i,
	input  logic [4:0]  raddr1_i,
	input  logic [4:0]  raddr2_i,
	output logic [31:0] rdata1_o,
	output logic [31:0] rdata2_o,
	input  logic        wen_i,
	input  logic [4:0]  waddr_i,
	input  logic [31:0] wdata_i
);

	logic [31:0] regs [`CORE_NUM_REGS];

	// combinational read, x0 hardwired
	assign rdata1_o = (raddr1_i == 5'd0) ? 32'd0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == 5'd0) ? 32'd0 : regs[raddr2_i];

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `CORE_NUM_REGS; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (wen_i && (waddr_i != 5'd0)) begin
			regs[waddr_i] <= wdata_i;
		end
	end

endmodule

// File: logic/exu_stage.sv
`include "core_config.svh"

module exu_stage
	import core_pkg::*;
(
	input  logic        clock,
	input  logic        rst_n_i,

	// fetch queue
	input  logic        fq_valid_i,
	input  fs_to_ds_t   fq_data_i,
	output logic        fq_pop_o,

	// retire queue
	input  logic        rq_credit_i,
	output logic        rq_push_o,
	output retire_t     rq_data_o,

	// register file
	output logic [4:0]  rs1_addr_o,
	output logic [4:0]  rs2_addr_o,
	input  logic [31:0] rs1_data_i,
	input  logic [31:0] rs2_data_i,
	output logic        rd_wen_o,
	output logic [4:0]  rd_addr_o,
	output logic [31:0] rd_wdata_o
);

	localparam logic [`CORE_CREDIT_W-1:0] INIT_CREDITS = `CORE_RQ_DEPTH;

	inst_t                     inst;
	alu_op_e                   alu_op;
	logic                      use_imm;
	logic                      legal;
	logic                      wen;
	logic                      fire;
	logic [31:0]               imm_i;
	logic [31:0]               imm_u;
	logic [31:0]               op_b;
	logic [31:0]               result;
	logic [`CORE_CREDIT_W-1:0] credit_q;

	assign inst  = fq_data_i.inst;
	assign imm_i = {{20{fq_data_i.inst[31]}}, fq_data_i.inst[31:20]};
	assign imm_u = {fq_data_i.inst[31:12], 12'h000};

	// decode, anything outside the subset stays illegal
	always_comb begin
		alu_op  = ALU_ADD;
		use_imm = 1'b0;
		legal   = 1'b0;
		case (inst.opcode)
			OP_IMM: begin
				use_imm = 1'b1;
				legal   = 1'b1;
				case (inst.funct3)
					F3_ADD:  alu_op = ALU_ADD;
					F3_XOR:  alu_op = ALU_XOR;
					F3_OR:   alu_op = ALU_OR;
					F3_AND:  alu_op = ALU_AND;
					default: legal  = 1'b0;
				endcase
			end
			OP_REG: begin
				legal = 1'b1;
				case ({inst.funct7, inst.funct3})
					{F7_BASE, F3_ADD}: alu_op = ALU_ADD;
					{F7_SUB, F3_ADD}:  alu_op = ALU_SUB;
					{F7_BASE, F3_XOR}: alu_op = ALU_XOR;
					{F7_BASE, F3_OR}:  alu_op = ALU_OR;
					{F7_BASE, F3_AND}: alu_op = ALU_AND;
					default:           legal  = 1'b0;
				endcase
			end
			OP_LUI: begin
				legal  = 1'b1;
				alu_op = ALU_LUI;
			end
			default: begin
				legal = 1'b0;
			end
		endcase
	end

	assign op_b = use_imm ? imm_i : rs2_data_i;

	always_comb begin
		case (alu_op)
			ALU_ADD: result = rs1_data_i + op_b;
			ALU_SUB: result = rs1_data_i - op_b;
			ALU_AND: result = rs1_data_i & op_b;
			ALU_OR:  result = rs1_data_i | op_b;
			ALU_XOR: result = rs1_data_i ^ op_b;
			ALU_LUI: result = imm_u;
			default: result = '0;
		endcase
	end

	// x0 writes are dropped here as well as in the register file
	assign wen = legal & (inst.rd != 5'd0);

	// consume only with a retire slot reserved
	assign fire       = fq_valid_i & (credit_q != '0);
	assign fq_pop_o   = fire;
	assign rq_push_o  = fire;
	assign rs1_addr_o = inst.rs1;
	assign rs2_addr_o = inst.rs2;
	assign rd_wen_o   = fire & wen;
	assign rd_addr_o  = inst.rd;
	assign rd_wdata_o = result;

	assign rq_data_o = '{
		pc:      fq_data_i.pc,
		rd:      inst.rd,
		wdata:   legal ? result : 32'd0,
		wen:     wen,
		illegal: ~legal
	};

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			credit_q <= INIT_CREDITS;
		end else begin
			case ({fire, rq_credit_i})
				2'b10:   credit_q <= credit_q - 1'b1;
				2'b01:   credit_q <= credit_q + 1'b1;
				default: credit_q <= credit_q;
			endcase
		end
	end

endmodule

// File: logic/credit_fifo.sv
module credit_fifo #(
	parameter type         payload_t = logic [31:0],
	parameter int unsigned DEPTH     = 4
) (
	input  logic     clock,
	input  logic     rst_n_i,

	// producer side, no ready since the producer holds credits
	input  logic     push_i,
	input  payload_t push_data_i,

	// consumer side
	input  logic     pop_i,
	output logic     valid_o,
	output payload_t data_o,

	// one pulse per freed slot, back to the producer
	output logic     credit_o
);

	localparam int unsigned      PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int unsigned      CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST  = PTR_W'(DEPTH - 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr_q;
	logic [PTR_W-1:0] wr_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic             do_pop;
	logic             credit_q;

	assign valid_o  = count_q != '0;
	assign data_o   = mem[rd_ptr_q];
	assign do_pop   = pop_i & valid_o;
	assign credit_o = credit_q;

	always_ff @(posedge clock) begin
		if (push_i) begin
			mem[wr_ptr_q] <= push_data_i;
		end
	end

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
			count_q  <= '0;
			credit_q <= 1'b0;
		end else begin
			// pointers wrap explicitly so any depth works
			if (push_i) begin
				wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
			end
			case ({push_i, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
			credit_q <= do_pop;
		end
	end

endmodule

// File: logic/ifu_stage.sv
`include "core_config.svh"

module ifu_stage
	import core_pkg::*;
(
	input  logic        clock,
	input  logic        rst_n_i,

	// instruction memory port
	output logic        inst_req_o,
	output logic [31:0] inst_addr_o,
	input  logic        inst_gnt_i,
	input  logic        inst_rvalid_i,
	input  logic [31:0] inst_data_i,

	// fetch queue side
	input  logic        credit_i,
	output logic        push_o,
	output fs_to_ds_t   push_data_o
);

	localparam logic [`CORE_CREDIT_W-1:0] INIT_CREDITS = `CORE_FQ_DEPTH;

	typedef enum logic [1:0] {
		S_IDLE,
		S_WAIT_GNT,
		S_WAIT_DATA
	} state_e;

	state_e                    state_q;
	state_e                    state_d;
	logic [31:0]               pc_q;
	logic [`CORE_CREDIT_W-1:0] credit_q;
	logic                      run_q;
	logic                      have_credit;
	logic                      issue;

	assign have_credit = credit_q != '0;

	// a request is only started with a free queue slot in hand
	always_comb begin
		inst_req_o = 1'b0;
		state_d    = state_q;
		case (state_q)
			S_IDLE: begin
				// no request before the first edge out of reset
				inst_req_o = run_q & have_credit;
				if (inst_req_o) begin
					state_d = inst_gnt_i ? S_WAIT_DATA : S_WAIT_GNT;
				end
			end
			S_WAIT_GNT: begin
				// keep the request stable until the memory takes it
				inst_req_o = 1'b1;
				if (inst_gnt_i) begin
					state_d = S_WAIT_DATA;
				end
			end
			S_WAIT_DATA: begin
				if (inst_rvalid_i) begin
					state_d = S_IDLE;
				end
			end
			default: begin
				state_d = S_IDLE;
			end
		endcase
	end

	assign issue       = inst_req_o & inst_gnt_i;
	assign inst_addr_o = pc_q;

	// returned word goes straight into the queue
	assign push_o      = (state_q == S_WAIT_DATA) & inst_rvalid_i;
	assign push_data_o = '{pc: pc_q, inst: inst_data_i};

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q  <= S_IDLE;
			pc_q     <= `CORE_RESET_PC;
			credit_q <= INIT_CREDITS;
			run_q    <= 1'b0;
		end else begin
			state_q <= state_d;
			run_q   <= 1'b1;
			if (push_o) begin
				pc_q <= pc_q + 32'd4;
			end
			// spend and return may land together
			case ({issue, credit_i})
				2'b10:   credit_q <= credit_q - 1'b1;
				2'b01:   credit_q <= credit_q + 1'b1;
				default: credit_q <= credit_q;
			endcase
		end
	end

endmodule

// File: logic/core_pkg.sv
package core_pkg;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		OP_IMM = 7'b0010011,
		OP_REG = 7'b0110011,
		OP_LUI = 7'b0110111
	} opcode_e;

	// funct3 / funct7 values for the arithmetic and logic ops
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB  = 7'b0100000;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_LUI
	} alu_op_e;

	// R-type field view of an instruction word
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
	} fs_to_ds_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [4:0]  rd;
		logic [31:0] wdata;
		logic        wen;
		logic        illegal;
	} retire_t;

endpackage

// File: include/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// address of the first fetch after reset
`define CORE_RESET_PC 32'h0000_0000

// fetch queue entries, also the starting credit count of the fetch stage
`define CORE_FQ_DEPTH 4

// retire queue entries, also the starting credit count of the execute stage
`define CORE_RQ_DEPTH 2

// credit counters must hold the larger of the two depths
`define CORE_CREDIT_W 3

// architectural integer registers
`define CORE_NUM_REGS 32

`endif
